//--- plru_top.f
design/plru_pkg.sv
design/plru_cfg_regs.sv
design/plru_tree_store.sv
design/plru_tree_logic.sv
design/plru_pipeline.sv
design/plru_top.sv
tests/plru_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f plru_top.f --top-module plru_tb -o plru_sim \
    && ./obj_dir/plru_sim | tee sim.log \
    && grep -q "Regression passed" sim.log \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }

//--- tests/plru_tb.sv
/*
 * Self-checking testbench for the PLRU replacement unit.
 * A reference model of all trees predicts every result two edges after
 * the request, and concurrent assertions sampled on the falling edge
 * compare the DUT outputs with it. APB tasks cover the register block.
 */
`timescale 1ns/1ps
`default_nettype none

module plru_tb
    import plru_pkg::*;
();

    localparam int CLK_PERIOD     = 10;
    localparam int RANDOM_REQS    = 400;
    localparam int TIMEOUT_CYCLES = 8 + RANDOM_REQS + 300 + 200;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clk_i;
    logic        rst_n_i;
    logic        hit_i;
    way_vec_t    hit_way_i;
    logic        evict_i;
    set_idx_t    set_i;
    way_vec_t    valid_ways_i;
    way_vec_t    dirty_ways_i;
    logic        hit_done_o;
    logic        victim_valid_o;
    way_vec_t    victim_way_o;
    logic        victim_dirty_o;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    apb_addr_t   paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;

    // Reference model state
    tree_bits_t  model_trees [NUM_SETS];
    way_vec_t    lock_model;
    int          dirty_evictions;
    logic [31:0] lfsr_state;
    int          cyc;
    int          result_errs;
    int          reg_errs;

    // Expected results, slot indexed by the cycle they appear in
    logic        exp_hit   [4];
    logic        exp_vv    [4];
    way_vec_t    exp_way   [4];
    logic        exp_dirty [4];
    way_vec_t    exp_valid [4];
    logic [1:0]  chk_slot;
    logic        cur_hit;
    logic        cur_vv;
    way_vec_t    cur_way;
    logic        cur_dirty;
    way_vec_t    cur_occ;
    logic        apb_bad;

    plru_top uut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .hit_i          (hit_i),
        .hit_way_i      (hit_way_i),
        .evict_i        (evict_i),
        .set_i          (set_i),
        .valid_ways_i   (valid_ways_i),
        .dirty_ways_i   (dirty_ways_i),
        .hit_done_o     (hit_done_o),
        .victim_valid_o (victim_valid_o),
        .victim_way_o   (victim_way_o),
        .victim_dirty_o (victim_dirty_o),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    assign chk_slot  = cyc[1:0];
    assign cur_hit   = exp_hit[chk_slot];
    assign cur_vv    = exp_vv[chk_slot];
    assign cur_way   = exp_way[chk_slot];
    assign cur_dirty = exp_dirty[chk_slot];
    assign cur_occ   = exp_valid[chk_slot] | lock_model;
    assign apb_bad   = (paddr_i != ADDR_SPM_LOCK) && (paddr_i != ADDR_DIRTY_CNT);

    // Outputs only move on the rising edge, so the falling edge sees them settled
    assert property (@(negedge clk_i) disable iff (!rst_n_i) hit_done_o == cur_hit)
        else begin
            result_errs = result_errs + 1;
            $display("FAIL hit_done_o: got %h expected %h", hit_done_o, cur_hit);
        end
    assert property (@(negedge clk_i) disable iff (!rst_n_i) victim_valid_o == cur_vv)
        else begin
            result_errs = result_errs + 1;
            $display("FAIL victim_valid_o: got %h expected %h", victim_valid_o, cur_vv);
        end
    assert property (@(negedge clk_i) disable iff (!rst_n_i) victim_way_o == cur_way)
        else begin
            result_errs = result_errs + 1;
            $display("FAIL victim_way_o: got %h expected %h", victim_way_o, cur_way);
        end
    assert property (@(negedge clk_i) disable iff (!rst_n_i) victim_dirty_o == cur_dirty)
        else begin
            result_errs = result_errs + 1;
            $display("FAIL victim_dirty_o: got %h expected %h", victim_dirty_o, cur_dirty);
        end
    // A free way must win while one is left
    assert property (@(negedge clk_i) disable iff (!rst_n_i)
                     !(victim_valid_o && (cur_occ != 8'hFF) && ((victim_way_o & cur_occ) != 8'h00)))
        else begin
            result_errs = result_errs + 1;
            $display("Victim way %h taken although a free way was left", victim_way_o);
        end
    assert property (@(negedge clk_i) disable iff (!rst_n_i)
                     !(victim_valid_o && (lock_model != 8'hFF)
                       && ((victim_way_o & lock_model) != 8'h00)))
        else begin
            result_errs = result_errs + 1;
            $display("Locked way %h chosen as victim", victim_way_o);
        end
    assert property (@(negedge clk_i) pslverr_o == (psel_i && penable_i && apb_bad))
        else begin
            result_errs = result_errs + 1;
            $display("FAIL pslverr_o: got %h expected %h", pslverr_o, psel_i && penable_i && apb_bad);
        end
    assert property (@(negedge clk_i) !(psel_i && penable_i) || pready_o)
        else begin
            result_errs = result_errs + 1;
            $display("FAIL pready_o: got %h expected %h", pready_o, 1'b1);
        end

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        out;
        r = '0;
        for (int i = 0; i < n; i++) begin
            out = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            r = {r[30:0], out};
        end
        return r;
    endfunction

    function automatic logic span_full(input way_vec_t mask, input int lo, input int cnt);
        for (int i = lo; i < lo + cnt; i++) begin
            if (!mask[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic int way_index(input way_vec_t way);
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (way[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    // Walk from the root, pointing each node at the half that holds the way
    function automatic tree_bits_t touch_way(input tree_bits_t bits, input int way);
        tree_bits_t nb;
        int         n;
        int         base;
        int         size;
        int         half;
        nb = bits;
        n = 0;
        base = 0;
        size = NUM_WAYS;
        while (size > 1) begin
            half = size / 2;
            if (way >= base + half) begin
                nb[n] = 1'b0;
                n = n + 1;
                base = base + half;
            end else begin
                nb[n] = 1'b1;
                n = n + half;
            end
            size = half;
        end
        return nb;
    endfunction

    function automatic int pick_victim(input tree_bits_t bits, input way_vec_t valid,
                                       input way_vec_t lock);
        way_vec_t occ;
        int       n;
        int       base;
        int       size;
        int       half;
        logic     up_blk;
        logic     lo_blk;
        logic     go_upper;
        occ = valid | lock;
        n = 0;
        base = 0;
        size = NUM_WAYS;
        while (size > 1) begin
            half = size / 2;
            if (span_full(occ, base, size)) begin
                up_blk = span_full(lock, base + half, half);
                lo_blk = span_full(lock, base, half);
            end else begin
                up_blk = span_full(occ, base + half, half);
                lo_blk = span_full(occ, base, half);
            end
            if (up_blk) begin
                go_upper = 1'b0;
            end else if (lo_blk) begin
                go_upper = 1'b1;
            end else begin
                // Node bit 1 means the lower half was used last
                go_upper = bits[n];
            end
            if (go_upper) begin
                n = n + 1;
                base = base + half;
            end else begin
                n = n + half;
            end
            size = half;
        end
        return base;
    endfunction

    // One clock, requests dropped unless the caller drives a new one
    task automatic step_cycle();
        logic [1:0] s;
        @(posedge clk_i);
        cyc = cyc + 1;
        s = 2'(cyc + 2);
        exp_hit[s]   = 1'b0;
        exp_vv[s]    = 1'b0;
        exp_way[s]   = '0;
        exp_dirty[s] = 1'b0;
        exp_valid[s] = '0;
        hit_i   <= 1'b0;
        evict_i <= 1'b0;
    endtask

    task automatic drain();
        repeat (4) step_cycle();
    endtask

    task automatic request(input logic hit, input logic evict, input way_vec_t hway,
                           input set_idx_t set, input way_vec_t valid, input way_vec_t dirty);
        logic [1:0] s;
        int         v;
        step_cycle();
        s = 2'(cyc + 2);
        hit_i        <= hit;
        evict_i      <= evict;
        hit_way_i    <= hway;
        set_i        <= set;
        valid_ways_i <= valid;
        dirty_ways_i <= dirty;
        if (hit) begin
            model_trees[set] = touch_way(model_trees[set], way_index(hway));
            exp_hit[s] = 1'b1;
        end else if (evict) begin
            v = pick_victim(model_trees[set], valid, lock_model);
            model_trees[set] = touch_way(model_trees[set], v);
            exp_vv[s]    = 1'b1;
            exp_way[s]   = way_vec_t'(1) << v;
            exp_dirty[s] = dirty[v];
            exp_valid[s] = valid;
            if (dirty[v]) begin
                dirty_evictions = dirty_evictions + 1;
            end
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
        step_cycle();
        psel_i    <= 1'b1;
        pwrite_i  <= 1'b1;
        paddr_i   <= addr;
        pwdata_i  <= data;
        penable_i <= 1'b0;
        step_cycle();
        penable_i <= 1'b1;
        step_cycle();
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data);
        step_cycle();
        psel_i    <= 1'b1;
        pwrite_i  <= 1'b0;
        paddr_i   <= addr;
        penable_i <= 1'b0;
        step_cycle();
        penable_i <= 1'b1;
        @(negedge clk_i);
        data = prdata_o;
        step_cycle();
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic check_read(input apb_addr_t addr, input logic [31:0] expected);
        logic [31:0] data;
        apb_read(addr, data);
        assert (data == expected) else begin
            reg_errs = reg_errs + 1;
            $display("FAIL prdata_o at %h: got %h expected %h", addr, data, expected);
        end
    endtask

    task automatic set_lock(input way_vec_t mask);
        drain();
        apb_write(ADDR_SPM_LOCK, {24'h0, mask});
        lock_model = mask;
    endtask

    initial begin
        logic [31:0] junk;
        logic [1:0]  op;
        set_idx_t    last_set;
        set_idx_t    rset;
        way_vec_t    rvalid;

        clk_i = 1'b0;
        rst_n_i = 1'b0;
        hit_i = 1'b0;
        hit_way_i = '0;
        evict_i = 1'b0;
        set_i = '0;
        valid_ways_i = '0;
        dirty_ways_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        lock_model = '0;
        dirty_evictions = 0;
        lfsr_state = 32'heb34_1a90;
        cyc = 0;
        result_errs = 0;
        reg_errs = 0;
        last_set = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_trees[s] = '0;
        end
        for (int s = 0; s < 4; s++) begin
            exp_hit[s] = 1'b0;
            exp_vv[s] = 1'b0;
            exp_way[s] = '0;
            exp_dirty[s] = 1'b0;
            exp_valid[s] = '0;
        end

        repeat (8) step_cycle();
        rst_n_i <= 1'b1;
        drain();

        // Fresh tree and empty set give way 0
        request(1'b0, 1'b1, '0, 4'd5, 8'h00, 8'h00);
        drain();

        // Register block
        apb_write(ADDR_SPM_LOCK, 32'h0000_01A5);
        check_read(ADDR_SPM_LOCK, 32'h0000_00A5);
        check_read(ADDR_DIRTY_CNT, 32'h0);
        apb_write(ADDR_DIRTY_CNT, 32'h0000_FFFF);
        check_read(ADDR_DIRTY_CNT, 32'h0);
        apb_read(4'h8, junk);
        apb_write(4'h8, 32'h1234_5678);
        set_lock(8'h00);

        // Hits steer the tree, then a back-to-back eviction follows it
        request(1'b1, 1'b0, 8'h04, 4'd3, 8'hFF, 8'h00);
        request(1'b1, 1'b0, 8'h40, 4'd3, 8'hFF, 8'h00);
        request(1'b1, 1'b0, 8'h20, 4'd3, 8'hFF, 8'h00);
        request(1'b1, 1'b0, 8'h01, 4'd3, 8'hFF, 8'h00);
        request(1'b1, 1'b0, 8'h80, 4'd3, 8'hFF, 8'h00);
        request(1'b0, 1'b1, '0, 4'd3, 8'hFF, 8'hFF);
        request(1'b0, 1'b1, '0, 4'd3, 8'hFF, 8'h0F);

        // Whole halves and scattered ways locked
        set_lock(8'hF0);
        repeat (4) request(1'b0, 1'b1, '0, 4'd7, 8'hFF, 8'h3C);
        request(1'b0, 1'b1, '0, 4'd7, 8'h05, 8'hFF);
        set_lock(8'h0F);
        repeat (4) request(1'b0, 1'b1, '0, 4'd7, 8'hFF, 8'hC3);
        request(1'b0, 1'b1, '0, 4'd8, 8'h90, 8'hFF);
        set_lock(8'h81);
        repeat (4) request(1'b0, 1'b1, '0, 4'd9, 8'hFF, 8'hFF);
        request(1'b0, 1'b1, '0, 4'd9, 8'h3C, 8'hFF);
        set_lock(8'h00);
        check_read(ADDR_DIRTY_CNT, 32'(dirty_evictions));

        // Random stream, half of the sets repeat to stress forwarding
        for (int i = 0; i < RANDOM_REQS; i++) begin
            if (i == RANDOM_REQS / 2) begin
                set_lock(8'h24);
            end
            op = 2'(take_bits(2));
            if (take_bits(1) != 0) begin
                rset = last_set;
            end else begin
                rset = set_idx_t'(take_bits(4));
            end
            if (take_bits(1) != 0) begin
                rvalid = 8'hFF;
            end else begin
                rvalid = way_vec_t'(take_bits(8));
            end
            request(op == 2'd1 || op == 2'd3, op[1], way_vec_t'(8'h01 << take_bits(3)),
                    rset, rvalid, way_vec_t'(take_bits(8)));
            last_set = rset;
        end
        drain();
        check_read(ADDR_DIRTY_CNT, 32'(dirty_evictions));
        drain();

        $display("Checks done with %0d result errors and %0d register errors",
                 result_errs, reg_errs);
        if (result_errs == 0 && reg_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/plru_top.sv
/*
 * Top level of the PLRU replacement unit.
 * Connects the APB register block, the tree store, the request pipeline
 * and the combinational tree logic.
 */
`timescale 1ns/1ps
`default_nettype none

module plru_top
    import plru_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    // Cache side
    input  wire logic        hit_i,
    input  wire way_vec_t    hit_way_i,
    input  wire logic        evict_i,
    input  wire set_idx_t    set_i,
    input  wire way_vec_t    valid_ways_i,
    input  wire way_vec_t    dirty_ways_i,
    output logic             hit_done_o,
    output logic             victim_valid_o,
    output way_vec_t         victim_way_o,
    output logic             victim_dirty_o,
    // APB
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire apb_addr_t   paddr_i,
    input  wire logic [31:0] pwdata_i,
    output logic      [31:0] prdata_o,
    output logic             pready_o,
    output logic             pslverr_o
);

    way_vec_t   spm_lock;
    logic       victim_dirty;
    logic       rd_en;
    set_idx_t   rd_set;
    tree_bits_t rd_bits;
    logic       wr_en;
    set_idx_t   wr_set;
    tree_bits_t wr_bits;
    tree_bits_t tree_bits;
    logic       is_evict;
    way_vec_t   s2_hit_way;
    way_vec_t   s2_valid_ways;
    tree_bits_t next_bits;
    way_vec_t   victim_way;

    plru_cfg_regs u_regs (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .victim_dirty_i (victim_dirty),
        .spm_lock_o     (spm_lock)
    );

    plru_tree_store u_store (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rd_en_i   (rd_en),
        .rd_set_i  (rd_set),
        .rd_bits_o (rd_bits),
        .wr_en_i   (wr_en),
        .wr_set_i  (wr_set),
        .wr_bits_i (wr_bits)
    );

    plru_pipeline u_pipe (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .hit_i           (hit_i),
        .evict_i         (evict_i),
        .hit_way_i       (hit_way_i),
        .set_i           (set_i),
        .valid_ways_i    (valid_ways_i),
        .dirty_ways_i    (dirty_ways_i),
        .rd_en_o         (rd_en),
        .rd_set_o        (rd_set),
        .rd_bits_i       (rd_bits),
        .wr_en_o         (wr_en),
        .wr_set_o        (wr_set),
        .wr_bits_o       (wr_bits),
        .bits_o          (tree_bits),
        .is_evict_o      (is_evict),
        .s2_hit_way_o    (s2_hit_way),
        .s2_valid_ways_o (s2_valid_ways),
        .next_bits_i     (next_bits),
        .victim_way_i    (victim_way),
        .hit_done_o      (hit_done_o),
        .victim_valid_o  (victim_valid_o),
        .victim_way_o    (victim_way_o),
        .victim_dirty_o  (victim_dirty)
    );

    plru_tree_logic u_logic (
        .is_evict_i   (is_evict),
        .bits_i       (tree_bits),
        .hit_way_i    (s2_hit_way),
        .valid_ways_i (s2_valid_ways),
        .spm_lock_i   (spm_lock),
        .next_bits_o  (next_bits),
        .victim_way_o (victim_way)
    );

    // Dirty flag goes out and also feeds the eviction counter
    assign victim_dirty_o = victim_dirty;

endmodule

`default_nettype wire

//--- design/plru_pipeline.sv
/*
 * Two-stage request pipeline around the tree store.
 * Stage 1 holds the request while the store is read, stage 2 feeds the
 * tree logic, drives the results and writes the updated tree back.
 * Same-set requests in flight get forwarded bits instead of stale reads.
 */
`timescale 1ns/1ps
`default_nettype none

module plru_pipeline
    import plru_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    // Cache requests
    input  wire logic       hit_i,
    input  wire logic       evict_i,
    input  wire way_vec_t   hit_way_i,
    input  wire set_idx_t   set_i,
    input  wire way_vec_t   valid_ways_i,
    input  wire way_vec_t   dirty_ways_i,
    // Tree store
    output logic            rd_en_o,
    output set_idx_t        rd_set_o,
    input  wire tree_bits_t rd_bits_i,
    output logic            wr_en_o,
    output set_idx_t        wr_set_o,
    output tree_bits_t      wr_bits_o,
    // Tree logic
    output tree_bits_t      bits_o,
    output logic            is_evict_o,
    output way_vec_t        s2_hit_way_o,
    output way_vec_t        s2_valid_ways_o,
    input  wire tree_bits_t next_bits_i,
    input  wire way_vec_t   victim_way_i,
    // Results
    output logic            hit_done_o,
    output logic            victim_valid_o,
    output way_vec_t        victim_way_o,
    output logic            victim_dirty_o
);

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_HIT,
        OP_EVICT
    } op_t;

    op_t        in_op;
    logic       in_fwd;
    logic       s2_fwd;

    op_t        s1_op;
    logic       s1_fwd;
    tree_bits_t s1_fwd_bits;
    set_idx_t   s1_set;
    way_vec_t   s1_hit_way;
    way_vec_t   s1_valid_ways;
    way_vec_t   s1_dirty_ways;

    op_t        s2_op;
    set_idx_t   s2_set;
    tree_bits_t s2_bits;
    way_vec_t   s2_hit_way;
    way_vec_t   s2_valid_ways;
    way_vec_t   s2_dirty_ways;

    // Hit takes priority over a simultaneous eviction
    always_comb begin
        if (hit_i) begin
            in_op = OP_HIT;
        end else if (evict_i) begin
            in_op = OP_EVICT;
        end else begin
            in_op = OP_IDLE;
        end
    end

    assign rd_en_o  = (in_op != OP_IDLE);
    assign rd_set_o = set_i;

    // Write on the read edge to the same set, the store returns the old bits
    assign in_fwd = wr_en_o && (wr_set_o == set_i);
    // Stage 2 result is newer than anything the store holds
    assign s2_fwd = (s2_op != OP_IDLE) && (s2_set == s1_set);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_op  <= OP_IDLE;
            s1_fwd <= 1'b0;
            s2_op  <= OP_IDLE;
        end else begin
            s1_op  <= in_op;
            s1_fwd <= in_fwd && rd_en_o;
            s2_op  <= s1_op;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_set        <= set_i;
        s1_hit_way    <= hit_way_i;
        s1_valid_ways <= valid_ways_i;
        s1_dirty_ways <= dirty_ways_i;
        s1_fwd_bits   <= next_bits_i;

        s2_set        <= s1_set;
        s2_hit_way    <= s1_hit_way;
        s2_valid_ways <= s1_valid_ways;
        s2_dirty_ways <= s1_dirty_ways;
        if (s2_fwd) begin
            s2_bits <= next_bits_i;
        end else if (s1_fwd) begin
            s2_bits <= s1_fwd_bits;
        end else begin
            s2_bits <= rd_bits_i;
        end
    end

    assign bits_o          = s2_bits;
    assign is_evict_o      = (s2_op == OP_EVICT);
    assign s2_hit_way_o    = s2_hit_way;
    assign s2_valid_ways_o = s2_valid_ways;

    // Write back the updated tree at the end of stage 2
    assign wr_en_o   = (s2_op != OP_IDLE);
    assign wr_set_o  = s2_set;
    assign wr_bits_o = next_bits_i;

    assign hit_done_o     = (s2_op == OP_HIT);
    assign victim_valid_o = is_evict_o;
    assign victim_way_o   = victim_valid_o ? victim_way_i : '0;
    assign victim_dirty_o = victim_valid_o && |(s2_dirty_ways & victim_way_i);

endmodule

`default_nettype wire

//--- design/plru_tree_logic.sv
/*
 * Combinational PLRU logic over one 8-way tree.
 * On eviction it walks the tree to a victim, avoiding locked and, while
 * possible, valid ways. The path to the hit way or victim forms next_bits_o.
 */
`timescale 1ns/1ps
`default_nettype none

module plru_tree_logic
    import plru_pkg::*;
(
    input  wire logic       is_evict_i,
    input  wire tree_bits_t bits_i,
    input  wire way_vec_t   hit_way_i,
    input  wire way_vec_t   valid_ways_i,
    input  wire way_vec_t   spm_lock_i,
    output tree_bits_t      next_bits_o,
    output way_vec_t        victim_way_o
);

    way_vec_t   occ;
    logic       g0;
    logic       g1;
    logic       g2;
    logic       n1;
    logic       n2;
    logic [3:0] quad_occ;
    logic [3:0] quad_lock;
    logic [1:0] pair_occ;
    logic [1:0] pair_lock;
    logic [2:0] victim_idx;
    way_vec_t   victim;
    way_vec_t   target;

    // One node decision, returns 1 to descend into the lower half
    function automatic logic go_lower(input logic node_bit,
                                      input logic up_occ,
                                      input logic lo_occ,
                                      input logic up_lock,
                                      input logic lo_lock);
        logic up_blk;
        logic lo_blk;
        if (up_occ && lo_occ) begin
            // Nothing free below, only locked halves are off limits
            up_blk = up_lock;
            lo_blk = lo_lock;
        end else begin
            up_blk = up_occ;
            lo_blk = lo_occ;
        end
        if (up_blk) begin
            return 1'b1;
        end else if (lo_blk) begin
            return 1'b0;
        end
        // Away from the most recently used half
        return ~node_bit;
    endfunction

    // Point every node on the path at the half holding the way
    function automatic tree_bits_t mark_path(input tree_bits_t bits, input way_vec_t way);
        tree_bits_t nb;
        nb = bits;
        if (|way[7:4]) begin
            nb[0] = 1'b0;
            nb[1] = ~(|way[7:6]);
            if (|way[7:6]) begin
                nb[2] = ~way[7];
            end else begin
                nb[3] = ~way[5];
            end
        end else begin
            nb[0] = 1'b1;
            nb[4] = ~(|way[3:2]);
            if (|way[3:2]) begin
                nb[5] = ~way[3];
            end else begin
                nb[6] = ~way[1];
            end
        end
        return nb;
    endfunction

    assign occ = valid_ways_i | spm_lock_i;

    always_comb begin
        // Root
        g0 = go_lower(bits_i[0], &occ[7:4], &occ[3:0], &spm_lock_i[7:4], &spm_lock_i[3:0]);

        // Quad under the chosen root half
        quad_occ  = g0 ? occ[3:0] : occ[7:4];
        quad_lock = g0 ? spm_lock_i[3:0] : spm_lock_i[7:4];
        n1        = g0 ? bits_i[4] : bits_i[1];
        g1 = go_lower(n1, &quad_occ[3:2], &quad_occ[1:0], &quad_lock[3:2], &quad_lock[1:0]);

        // Leaf pair
        pair_occ  = g1 ? quad_occ[1:0] : quad_occ[3:2];
        pair_lock = g1 ? quad_lock[1:0] : quad_lock[3:2];
        if (g0) begin
            n2 = g1 ? bits_i[6] : bits_i[5];
        end else begin
            n2 = g1 ? bits_i[3] : bits_i[2];
        end
        g2 = go_lower(n2, pair_occ[1], pair_occ[0], pair_lock[1], pair_lock[0]);

        victim_idx = {~g0, ~g1, ~g2};
        victim     = way_vec_t'(1) << victim_idx;
    end

    assign target       = is_evict_i ? victim : hit_way_i;
    assign next_bits_o  = mark_path(bits_i, target);
    assign victim_way_o = victim;

endmodule

`default_nettype wire

//--- design/plru_tree_store.sv
/*
 * Register array with one PLRU tree per set.
 * Registered read port and synchronous write port; a read that meets a
 * write to the same set returns the bits from before the write.
 */
`timescale 1ns/1ps
`default_nettype none

module plru_tree_store
    import plru_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    // Read port, data one cycle after rd_en_i
    input  wire logic       rd_en_i,
    input  wire set_idx_t   rd_set_i,
    output tree_bits_t      rd_bits_o,
    // Write port
    input  wire logic       wr_en_i,
    input  wire set_idx_t   wr_set_i,
    input  wire tree_bits_t wr_bits_i
);

    tree_bits_t trees_q [NUM_SETS];
    tree_bits_t rd_bits_q;

    // All trees start at zero so the first victim is way 0
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                trees_q[s] <= '0;
            end
        end else if (wr_en_i) begin
            trees_q[wr_set_i] <= wr_bits_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_bits_q <= '0;
        end else if (rd_en_i) begin
            rd_bits_q <= trees_q[rd_set_i];
        end
    end

    assign rd_bits_o = rd_bits_q;

endmodule

`default_nettype wire

//--- design/plru_cfg_regs.sv
/*
 * APB3 register block beside the replacement logic.
 * Holds the scratchpad lock mask and a saturating count of dirty evictions.
 * No wait states; unknown offsets answer with pslverr_o.
 */
`timescale 1ns/1ps
`default_nettype none

module plru_cfg_regs
    import plru_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    // APB slave
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire apb_addr_t   paddr_i,
    input  wire logic [31:0] pwdata_i,
    output logic      [31:0] prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    // Replacement side
    input  wire logic        victim_dirty_i,
    output way_vec_t         spm_lock_o
);

    way_vec_t spm_lock_q;
    cnt_t     dirty_cnt_q;
    logic     access;
    logic     addr_ok;

    // Access phase of a transfer
    assign access  = psel_i && penable_i;
    assign addr_ok = (paddr_i == ADDR_SPM_LOCK) || (paddr_i == ADDR_DIRTY_CNT);

    assign pready_o  = 1'b1;
    assign pslverr_o = access && !addr_ok;

    always_comb begin
        prdata_o = '0;
        if (paddr_i == ADDR_SPM_LOCK) begin
            prdata_o = {{(32-NUM_WAYS){1'b0}}, spm_lock_q};
        end else if (paddr_i == ADDR_DIRTY_CNT) begin
            prdata_o = {{(32-CNT_W){1'b0}}, dirty_cnt_q};
        end
    end

    // Lock mask, written from the low byte
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spm_lock_q <= '0;
        end else if (access && pwrite_i && (paddr_i == ADDR_SPM_LOCK)) begin
            spm_lock_q <= pwdata_i[NUM_WAYS-1:0];
        end
    end

    // Dirty eviction counter, read only, sticks at all ones
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dirty_cnt_q <= '0;
        end else if (victim_dirty_i && (dirty_cnt_q != '1)) begin
            dirty_cnt_q <= dirty_cnt_q + cnt_t'(1);
        end
    end

    assign spm_lock_o = spm_lock_q;

endmodule

`default_nettype wire

//--- design/plru_pkg.sv
/*
 * Shared sizes, types and register offsets of the PLRU replacement unit.
 * Every RTL file pulls these in with a wildcard import in its module header.
 */
`default_nettype none

package plru_pkg;

    // Cache geometry
    localparam int unsigned NUM_WAYS  = 8;
    localparam int unsigned NUM_SETS  = 16;
    localparam int unsigned TREE_W    = NUM_WAYS - 1;
    localparam int unsigned SET_IDX_W = 4;

    // APB register block
    localparam int unsigned APB_ADDR_W = 4;
    localparam int unsigned CNT_W      = 16;

    // One bit per way, used both as a one-hot way and as a mask
    typedef logic [NUM_WAYS-1:0]   way_vec_t;
    typedef logic [SET_IDX_W-1:0]  set_idx_t;
    // Node 0 is the root, 1..3 cover ways 7..4, 4..6 cover ways 3..0
    typedef logic [TREE_W-1:0]     tree_bits_t;
    typedef logic [CNT_W-1:0]      cnt_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    // Register offsets
    localparam apb_addr_t ADDR_SPM_LOCK  = 4'h0;
    localparam apb_addr_t ADDR_DIRTY_CNT = 4'h4;

endpackage

`default_nettype wire
